/* verilog/ctr_pkg.sv */
// Shared widths and encodings for the sliced counter-increment unit, used by scoped name
package ctr_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Full counter, one 128-bit word
  parameter int CtrWidth = 128;

  // One bit per control rail
  parameter int Sp2VWidth = 2;

  ////////////////////////////////////////
  // Sparse two-rail encodings
  ////////////////////////////////////////

  // Bit 0 belongs to the positive rail, bit 1 to the negative rail
  // Valid codes are 01 and 10, both 00 and 11 are illegal
  parameter logic [Sp2VWidth-1:0] SP2V_HIGH = 2'b01;
  parameter logic [Sp2VWidth-1:0] SP2V_LOW  = 2'b10;

  ////////////////////////////////////////
  // Increment FSM states
  ////////////////////////////////////////

  // Pairwise Hamming distance of two
  // A single flipped bit never lands on another legal state
  typedef enum logic [2:0] {
    IDLE  = 3'b011,
    INCR  = 3'b101,
    ERROR = 3'b110
  } ctr_state_e;

endpackage

/* verilog/ctr_slice_cnt.sv */
// Slice index counter for the increment FSM, cleared per request and stepped once per slice
module ctr_slice_cnt #(
  parameter int SliceWidth = 16,
  localparam int NumSlices = ctr_pkg::CtrWidth / SliceWidth,
  localparam int IdxWidth = $clog2(NumSlices)
) (
  input  logic                clk_i,
  input  logic                rst_i,

  // Control from the FSM
  input  logic                clr_i,
  input  logic                step_i,

  // Current slice and top-slice flag
  output logic [IdxWidth-1:0] idx_o,
  output logic                last_o
);

  logic [IdxWidth-1:0] idx_q;

  // Index register
  // Clear wins over step
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      idx_q <= '0;
    end else if (clr_i) begin
      idx_q <= '0;
    end else if (step_i) begin
      idx_q <= idx_q + IdxWidth'(1);
    end
  end

  assign idx_o = idx_q;

  // Top slice reached, no further carry possible
  assign last_o = (idx_q == IdxWidth'(NumSlices - 1));

endmodule

/* verilog/ctr_slice_fsm.sv */
// One control rail of the counter increment, instantiated twice with opposite pin polarity
module ctr_slice_fsm #(
  parameter int SliceWidth = 16,
  parameter bit ActiveLow = 1'b0,
  localparam int NumSlices = ctr_pkg::CtrWidth / SliceWidth,
  localparam int IdxWidth = $clog2(NumSlices)
) (
  input  logic                  clk_i,
  input  logic                  rst_i,

  // Request and error inputs
  input  logic                  incr_i,
  input  logic                  incr_err_i,
  input  logic                  mr_err_i,

  // Slice read back from the datapath
  input  logic [SliceWidth-1:0] ctr_slice_i,

  // Sparse single bits, polarity set by ActiveLow
  output logic                  ready_o,
  output logic                  ctr_we_o,

  // OR-combined outputs, zero when not valid
  output logic                  alert_o,
  output logic [IdxWidth-1:0]   ctr_slice_idx_o,
  output logic [SliceWidth-1:0] ctr_slice_o
);

  ctr_pkg::ctr_state_e state_d, state_q;

  logic                carry_d, carry_q;
  logic                incr;
  logic                ready;
  logic                ctr_we;
  logic                cnt_clr;
  logic                cnt_step;
  logic                cnt_last;
  logic [IdxWidth-1:0] cnt_idx;
  logic [SliceWidth:0] slice_sum;

  // Pin polarity
  assign incr = ActiveLow ? ~incr_i : incr_i;

  // Slice adder, MSB is the carry out
  assign slice_sum = {1'b0, ctr_slice_i} + {{SliceWidth{1'b0}}, carry_q};

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    carry_d  = carry_q;
    ready    = 1'b0;
    ctr_we   = 1'b0;
    cnt_clr  = 1'b0;
    cnt_step = 1'b0;

    case (state_q)
      ctr_pkg::IDLE: begin
        ready = 1'b1;
        // Start at slice 0 with the +1 as incoming carry
        if (incr) begin
          state_d = ctr_pkg::INCR;
          carry_d = 1'b1;
          cnt_clr = 1'b1;
        end
      end
      ctr_pkg::INCR: begin
        ctr_we   = 1'b1;
        cnt_step = 1'b1;
        carry_d  = slice_sum[SliceWidth];
        // Done on no carry out or after the top slice
        if (!slice_sum[SliceWidth] || cnt_last) begin
          state_d = ctr_pkg::IDLE;
        end
      end
      ctr_pkg::ERROR: begin
        // Terminal until reset
        state_d = ctr_pkg::ERROR;
      end
      default: begin
        state_d = ctr_pkg::ERROR;
      end
    endcase

    // Any error overrides, no further slice writes
    if (incr_err_i || mr_err_i) begin
      state_d  = ctr_pkg::ERROR;
      ctr_we   = 1'b0;
      cnt_step = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ctr_pkg::IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      carry_q <= carry_d;
    end
  end

  ctr_slice_cnt #(
    .SliceWidth ( SliceWidth )
  ) u_slice_cnt (
    .clk_i  ( clk_i    ),
    .rst_i  ( rst_i    ),
    .clr_i  ( cnt_clr  ),
    .step_i ( cnt_step ),
    .idx_o  ( cnt_idx  ),
    .last_o ( cnt_last )
  );

  // Sparse pins
  assign ready_o  = ActiveLow ? ~ready : ready;
  assign ctr_we_o = ActiveLow ? ~ctr_we : ctr_we;

  // Only driven while valid so the rail OR stays sound
  assign alert_o         = (state_q == ctr_pkg::ERROR);
  assign ctr_slice_idx_o = (state_q == ctr_pkg::INCR) ? cnt_idx : '0;
  assign ctr_slice_o     = (state_q == ctr_pkg::INCR) ? slice_sum[SliceWidth-1:0] : '0;

endmodule

/* verilog/ctr_rail_cmp.sv */
// Combines the two rail copies of one payload by OR and flags any disagreement between them
module ctr_rail_cmp #(
  parameter type payload_t = logic [15:0]
) (
  // One entry per rail
  input  payload_t [ctr_pkg::Sp2VWidth-1:0] rail_i,

  // Combined value and disagreement flag
  output payload_t                          comb_o,
  output logic                              mismatch_o
);

  payload_t comb;
  logic     mismatch;

  ////////////////////////////////////////
  // Combine and compare
  ////////////////////////////////////////

  always_comb begin
    comb     = '0;
    mismatch = 1'b0;

    // Invalid rails drive zero, so OR yields the valid value
    for (int i = 0; i < ctr_pkg::Sp2VWidth; i++) begin
      comb |= rail_i[i];
    end

    // Every rail must agree with the combination
    for (int i = 0; i < ctr_pkg::Sp2VWidth; i++) begin
      if (rail_i[i] != comb) begin
        mismatch = 1'b1;
      end
    end
  end

  assign comb_o     = comb;
  assign mismatch_o = mismatch;

endmodule

/* verilog/ctr_byte_order.sv */
// Counter datapath: picks the current slice and merges the updated slice back into the counter
module ctr_byte_order #(
  parameter int SliceWidth = 16,
  localparam int NumSlices = ctr_pkg::CtrWidth / SliceWidth,
  localparam int IdxWidth = $clog2(NumSlices)
) (
  // Big-endian counter, byte 0 in bits 7:0 is most significant
  input  logic [ctr_pkg::CtrWidth-1:0] ctr_i,

  // Slice position and new slice value
  input  logic [IdxWidth-1:0]          slice_idx_i,
  input  logic [SliceWidth-1:0]        slice_i,

  // Current slice and merged counter
  output logic [SliceWidth-1:0]        ctr_slice_o,
  output logic [ctr_pkg::CtrWidth-1:0] ctr_next_o
);

  localparam int NumBytes = ctr_pkg::CtrWidth / 8;

  logic [NumSlices-1:0][SliceWidth-1:0] ctr_rev;
  logic [NumSlices-1:0][SliceWidth-1:0] ctr_next_rev;

  // Byte swap, its own inverse
  function automatic logic [ctr_pkg::CtrWidth-1:0] rev_bytes(
    input logic [ctr_pkg::CtrWidth-1:0] din
  );
    logic [ctr_pkg::CtrWidth-1:0] dout;
    for (int i = 0; i < NumBytes; i++) begin
      dout[8*i +: 8] = din[8*(NumBytes-1-i) +: 8];
    end
    return dout;
  endfunction

  // Slice 0 becomes least significant
  assign ctr_rev = rev_bytes(ctr_i);

  // Slice read for the rails
  assign ctr_slice_o = ctr_rev[slice_idx_i];

  // Overwrite one slice, keep the rest
  always_comb begin
    ctr_next_rev              = ctr_rev;
    ctr_next_rev[slice_idx_i] = slice_i;
  end

  // Back to big-endian
  assign ctr_next_o = rev_bytes(ctr_next_rev);

endmodule

/* verilog/ctr_state_reg.sv */
// Holds the 128-bit counter value, written by a full load or by one merged slice update
module ctr_state_reg (
  input  logic                         clk_i,
  input  logic                         rst_i,

  // Full load, already gated by ready at the top
  input  logic                         load_i,
  input  logic [ctr_pkg::CtrWidth-1:0] load_data_i,

  // Slice write with the merged next value
  input  logic                         we_i,
  input  logic [ctr_pkg::CtrWidth-1:0] ctr_next_i,

  output logic [ctr_pkg::CtrWidth-1:0] ctr_o
);

  logic [ctr_pkg::CtrWidth-1:0] ctr_q;

  ////////////////////////////////////////
  // Counter register
  ////////////////////////////////////////

  // Load has priority over a slice write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctr_q <= '0;
    end else if (load_i) begin
      ctr_q <= load_data_i;
    end else if (we_i) begin
      ctr_q <= ctr_next_i;
    end
  end

  assign ctr_o = ctr_q;

endmodule

/* verilog/ctr_incr_top.sv */
// Top level of the counter-increment unit: input check, two control rails, datapath and counter
module ctr_incr_top #(
  parameter int SliceWidth = 16,
  localparam int NumSlices = ctr_pkg::CtrWidth / SliceWidth,
  localparam int IdxWidth = $clog2(NumSlices)
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          load_i,
  input  logic [ctr_pkg::CtrWidth-1:0]  load_data_i,
  input  logic [ctr_pkg::Sp2VWidth-1:0] incr_i,
  output logic [ctr_pkg::Sp2VWidth-1:0] ready_o,
  output logic [ctr_pkg::CtrWidth-1:0]  ctr_o,
  output logic                          alert_o
);

  logic                                           incr_err, mr_err, load_ok, ctr_we;
  logic                                           idx_mismatch, slice_mismatch;
  logic [ctr_pkg::Sp2VWidth-1:0]                  sp_incr, sp_ready, sp_ctr_we, mr_alert;
  logic [ctr_pkg::Sp2VWidth-1:0][IdxWidth-1:0]    mr_slice_idx;
  logic [ctr_pkg::Sp2VWidth-1:0][SliceWidth-1:0]  mr_slice;
  logic [IdxWidth-1:0]                            slice_idx;
  logic [SliceWidth-1:0]                          slice_new, ctr_slice;
  logic [ctr_pkg::CtrWidth-1:0]                   ctr_next;

  ////////////////////////////////////////
  // Inputs
  ////////////////////////////////////////

  // 00 and 11 are illegal
  assign incr_err = (incr_i != ctr_pkg::SP2V_HIGH) && (incr_i != ctr_pkg::SP2V_LOW);

  // Load only when idle, a same-cycle request is dropped in favour of it
  assign load_ok = load_i && (ready_o == ctr_pkg::SP2V_HIGH);
  assign sp_incr = load_ok ? ctr_pkg::SP2V_LOW : incr_i;

  ////////////////////////////////////////
  // Redundant rails
  ////////////////////////////////////////

  // Rail 0 positive, rail 1 negative
  for (genvar i = 0; i < ctr_pkg::Sp2VWidth; i++) begin : gen_rail
    ctr_slice_fsm #(
      .SliceWidth ( SliceWidth                       ),
      .ActiveLow  ( ctr_pkg::SP2V_HIGH[i] == 1'b0    )
    ) u_fsm (
      .clk_i           ( clk_i           ),
      .rst_i           ( rst_i           ),
      .incr_i          ( sp_incr[i]      ),
      .incr_err_i      ( incr_err        ),
      .mr_err_i        ( mr_err          ),
      .ctr_slice_i     ( ctr_slice       ),
      .ready_o         ( sp_ready[i]     ),
      .ctr_we_o        ( sp_ctr_we[i]    ),
      .alert_o         ( mr_alert[i]     ),
      .ctr_slice_idx_o ( mr_slice_idx[i] ),
      .ctr_slice_o     ( mr_slice[i]     )
    );
  end

  // Index copies
  ctr_rail_cmp #(.payload_t(logic [IdxWidth-1:0])) u_idx_cmp (
    .rail_i (mr_slice_idx), .comb_o (slice_idx), .mismatch_o (idx_mismatch)
  );

  // Slice data copies
  ctr_rail_cmp #(.payload_t(logic [SliceWidth-1:0])) u_slice_cmp (
    .rail_i (mr_slice), .comb_o (slice_new), .mismatch_o (slice_mismatch)
  );

  assign mr_err  = idx_mismatch | slice_mismatch;
  assign alert_o = |mr_alert;
  assign ready_o = sp_ready;

  // Write needs both rails to agree
  assign ctr_we = sp_ctr_we[0] & ~sp_ctr_we[1];

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  ctr_byte_order #(.SliceWidth(SliceWidth)) u_byte_order (
    .ctr_i       ( ctr_o     ),
    .slice_idx_i ( slice_idx ),
    .slice_i     ( slice_new ),
    .ctr_slice_o ( ctr_slice ),
    .ctr_next_o  ( ctr_next  )
  );

  ctr_state_reg u_state_reg (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .load_i      ( load_ok     ),
    .load_data_i ( load_data_i ),
    .we_i        ( ctr_we      ),
    .ctr_next_i  ( ctr_next    ),
    .ctr_o       ( ctr_o       )
  );

endmodule

/* dv/ctr_incr_checker.sv */
// Protocol assertions for the counter-increment top level, attached to ctr_incr_top by bind
module ctr_incr_checker #(
  parameter int SliceWidth = 16,
  localparam int NumSlices = ctr_pkg::CtrWidth / SliceWidth
) (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic [ctr_pkg::Sp2VWidth-1:0] ready_o,
  input logic [ctr_pkg::CtrWidth-1:0]  ctr_o,
  input logic                          alert_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions so far, watched by the testbench
  int unsigned fail_count = 0;

  // Aligned slices that differ between two counter values
  // Byte reversal keeps each slice contiguous and aligned
  function automatic int slices_changed(input logic [ctr_pkg::CtrWidth-1:0] a,
                                        input logic [ctr_pkg::CtrWidth-1:0] b);
    int n;
    n = 0;
    for (int s = 0; s < NumSlices; s++) begin
      if (a[s*SliceWidth +: SliceWidth] != b[s*SliceWidth +: SliceWidth]) begin
        n++;
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Only the two legal sparse codes
  ready_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    (ready_o == ctr_pkg::SP2V_HIGH) || (ready_o == ctr_pkg::SP2V_LOW))
    else begin
      $error("ready_o left the sparse encoding");
      fail_count++;
    end

  // Sticky until reset
  alert_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    alert_o |=> alert_o)
    else begin
      $error("alert_o dropped without reset");
      fail_count++;
    end

  // Busy cycles write at most one slice
  one_slice_per_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    (ready_o == ctr_pkg::SP2V_LOW) |=> (slices_changed($past(ctr_o), ctr_o) <= 1))
    else begin
      $error("ctr_o changed in more than one slice");
      fail_count++;
    end

endmodule

bind ctr_incr_top ctr_incr_checker #(.SliceWidth(SliceWidth)) u_checker (
  .clk_i   ( clk_i   ),
  .rst_i   ( rst_i   ),
  .ready_o ( ready_o ),
  .ctr_o   ( ctr_o   ),
  .alert_o ( alert_o )
);

/* dv/tb_ctr_incr_top.sv */
// Testbench for ctr_incr_top: loads, increments, busy-time stimulus and an illegal request
module tb_ctr_incr_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SliceWidth = 16;
  localparam int Timeout = 50;

  logic                          clk_i;
  logic                          rst_i;
  logic                          load_i;
  logic [ctr_pkg::CtrWidth-1:0]  load_data_i;
  logic [ctr_pkg::Sp2VWidth-1:0] incr_i;
  logic [ctr_pkg::Sp2VWidth-1:0] ready_o;
  logic [ctr_pkg::CtrWidth-1:0]  ctr_o;
  logic                          alert_o;

  // Reference count as a plain number
  logic [ctr_pkg::CtrWidth-1:0]  model_val;
  int                            seed = 32'h29fd;

  ctr_incr_top #(.SliceWidth(SliceWidth)) u_ctr_incr_top (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .load_i      ( load_i      ),
    .load_data_i ( load_data_i ),
    .incr_i      ( incr_i      ),
    .ready_o     ( ready_o     ),
    .ctr_o       ( ctr_o       ),
    .alert_o     ( alert_o     )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Any bound assertion failure ends the run
  initial begin
    wait (u_ctr_incr_top.u_checker.fail_count != 0);
    $display("TEST FAIL");
    $fatal(1, "A bound protocol assertion failed");
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Big-endian wire format, byte 0 in bits 7:0 is most significant
  function automatic logic [ctr_pkg::CtrWidth-1:0] to_wire(input logic [ctr_pkg::CtrWidth-1:0] v);
    logic [ctr_pkg::CtrWidth-1:0] r;
    r = '0;
    for (int k = 0; k < ctr_pkg::CtrWidth / 8; k++) begin
      r = {r[ctr_pkg::CtrWidth-9:0], v[8*k +: 8]};
    end
    return r;
  endfunction

  function automatic logic [ctr_pkg::CtrWidth-1:0] random_word();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic check_value(input string name, input logic [ctr_pkg::CtrWidth-1:0] exp,
                             input logic [ctr_pkg::CtrWidth-1:0] act);
    assert (act === exp) else begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "Value check failed");
    end
  endtask

  // Ends on a falling edge with ready high
  task automatic wait_idle(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (ready_o != ctr_pkg::SP2V_HIGH) begin
      if (cycles >= Timeout) begin
        $display("Timed out in %s waiting for ready_o to return high", name);
        $display("TEST FAIL");
        $fatal(1, "Timeout");
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  task automatic load_count(input string name, input logic [ctr_pkg::CtrWidth-1:0] val);
    wait_idle(name);
    @(posedge clk_i);
    load_i      <= 1'b1;
    load_data_i <= to_wire(val);
    @(posedge clk_i);
    load_i      <= 1'b0;
    model_val = val;
    @(negedge clk_i);
    check_value(name, to_wire(model_val), ctr_o);
  endtask

  task automatic incr_count(input string name);
    wait_idle(name);
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_HIGH;
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_LOW;
    model_val = model_val + 1'b1;
    wait_idle(name);
    check_value(name, to_wire(model_val), ctr_o);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    rst_i       = 1'b1;
    load_i      = 1'b0;
    load_data_i = '0;
    incr_i      = ctr_pkg::SP2V_LOW;
    model_val   = '0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    // Reset values, then count up from zero
    @(negedge clk_i);
    check_value("reset_ready", ctr_pkg::SP2V_HIGH, ready_o);
    check_value("reset_alert", 1'b0, alert_o);
    check_value("reset_ctr", '0, ctr_o);
    repeat (3) incr_count("from_zero");

    // Random start points
    for (int i = 0; i < 3; i++) begin
      load_count("random_load", to_wire(random_word()));
      repeat (2) incr_count("random_incr");
    end

    // Carry chains
    load_count("carry_load", 128'h0123_4567_89ab_cdef_0000_ffff_ffff_ffff);
    incr_count("carry_three_slices");
    load_count("carry_load", 128'h7fff_ffff_ffff_ffff_ffff_ffff_ffff_ffff);
    incr_count("carry_all_slices");
    load_count("wrap_load", '1);
    incr_count("wrap_to_zero");

    // Busy window, second request and a load are dropped
    load_count("busy_load", 128'h0000_1111_2222_3333_4444_ffff_ffff_ffff);
    wait_idle("busy_ignore");
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_HIGH;
    @(posedge clk_i);
    load_i      <= 1'b1;
    load_data_i <= random_word();
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_LOW;
    load_i <= 1'b0;
    model_val = model_val + 1'b1;
    wait_idle("busy_ignore");
    check_value("busy_ignore", to_wire(model_val), ctr_o);

    // Illegal 11 request locks the unit
    incr_count("before_error");
    @(posedge clk_i);
    incr_i <= 2'b11;
    @(posedge clk_i);
    incr_i      <= ctr_pkg::SP2V_HIGH;
    load_i      <= 1'b1;
    load_data_i <= random_word();
    repeat (4) @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_LOW;
    load_i <= 1'b0;
    @(negedge clk_i);
    check_value("error_alert", 1'b1, alert_o);
    check_value("error_ready", ctr_pkg::SP2V_LOW, ready_o);
    check_value("error_ctr_held", to_wire(model_val), ctr_o);

    repeat (2) @(negedge clk_i);
    if (u_ctr_incr_top.u_checker.fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "Bound assertions reported failures");
    end
  end

endmodule

/* project.f */
verilog/ctr_pkg.sv
verilog/ctr_slice_cnt.sv
verilog/ctr_slice_fsm.sv
verilog/ctr_rail_cmp.sv
verilog/ctr_byte_order.sv
verilog/ctr_state_reg.sv
verilog/ctr_incr_top.sv
dv/ctr_incr_checker.sv
dv/tb_ctr_incr_top.sv
